// File: design/core_pkg.sv
// core back-end package.
// Shared widths, the memory-operation encoding and the pipeline stage records.
package core_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    // memory operation carried from execute into the memory stage.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_e;

    // alu_result is the address for memory operations, the result otherwise.
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [INST_W-1:0]     inst;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_ena;
        mem_op_e               mem_op;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [INST_W-1:0]     inst;
        logic [XLEN-1:0]       rd_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_ena;
    } mem_wb_t;

    // if_s sits in bit 0 and wb_s in bit 4.
    typedef struct packed {
        logic wb_s;
        logic mem_s;
        logic ex_s;
        logic id_s;
        logic if_s;
    } stall_vec_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
        logic              trap;
        logic [XLEN-1:0]   trap_code;
    } commit_t;

endpackage

// File: design/data_ram.sv
// data RAM for the memory stage.
// Combinational word read, synchronous write with one enable per byte.
`timescale 1ns/10ps

module data_ram #(
    parameter int  DMEM_WORDS = 256,
    localparam int IDX_W      = $clog2(DMEM_WORDS)
) (
    input  logic                     clk,
    input  logic [IDX_W-1:0]         addr_i,
    input  logic [core_pkg::XLEN-1:0] wdata_i,
    input  logic [7:0]               be_i,
    input  logic                     we_i,
    output logic [core_pkg::XLEN-1:0] rdata_o
);

    import core_pkg::*;

    logic [XLEN-1:0] mem_q [DMEM_WORDS];

    assign rdata_o = mem_q[addr_i];

    // each enabled byte lane is written on its own.
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 8; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: design/mem_stage.sv
// memory stage with the EX/MEM register.
// Places store data in its byte lanes and aligns and extends load data.
`timescale 1ns/10ps

module mem_stage #(
    parameter int  DMEM_WORDS = 256,
    localparam int IDX_W      = $clog2(DMEM_WORDS)
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  core_pkg::ex_mem_t         ex_i,
    input  core_pkg::stall_vec_t      stall_i,
    input  logic                      flush_i,
    output logic [IDX_W-1:0]          ram_addr_o,
    output logic [core_pkg::XLEN-1:0] ram_wdata_o,
    output logic [7:0]                ram_be_o,
    output logic                      ram_we_o,
    input  logic [core_pkg::XLEN-1:0] ram_rdata_i,
    output core_pkg::mem_wb_t         mem_o
);

    import core_pkg::*;

    ex_mem_t         ex_mem_q;
    logic [2:0]      byte_off;
    logic [7:0]      lane_mask;
    logic            is_store;
    logic [XLEN-1:0] load_word;
    logic [XLEN-1:0] rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else if (flush_i) begin
            ex_mem_q <= '0;
        end else if (stall_i.mem_s) begin
            ex_mem_q <= ex_mem_q;
        end else if (stall_i.ex_s) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_i;
        end
    end

    assign byte_off   = ex_mem_q.alu_result[2:0];
    assign ram_addr_o = ex_mem_q.alu_result[IDX_W+2:3];

    always_comb begin
        lane_mask = 8'h00;
        is_store  = 1'b1;
        case (ex_mem_q.mem_op)
            MEM_SB:  lane_mask = 8'h01;
            MEM_SH:  lane_mask = 8'h03;
            MEM_SW:  lane_mask = 8'h0f;
            MEM_SD:  lane_mask = 8'hff;
            default: is_store = 1'b0;
        endcase
    end

    // a held store writes on the edge it leaves the stage, and a flush drops it.
    assign ram_we_o    = is_store && !stall_i.mem_s && !flush_i;
    assign ram_be_o    = lane_mask << byte_off;
    assign ram_wdata_o = ex_mem_q.store_data << {byte_off, 3'b000};

    always_comb begin
        load_word = ram_rdata_i >> {byte_off, 3'b000};
        case (ex_mem_q.mem_op)
            MEM_LB:  rd_data = {{(XLEN-8){load_word[7]}}, load_word[7:0]};
            MEM_LH:  rd_data = {{(XLEN-16){load_word[15]}}, load_word[15:0]};
            MEM_LW:  rd_data = {{(XLEN-32){load_word[31]}}, load_word[31:0]};
            MEM_LD:  rd_data = load_word;
            MEM_LBU: rd_data = {{(XLEN-8){1'b0}}, load_word[7:0]};
            MEM_LHU: rd_data = {{(XLEN-16){1'b0}}, load_word[15:0]};
            MEM_LWU: rd_data = {{(XLEN-32){1'b0}}, load_word[31:0]};
            default: rd_data = ex_mem_q.alu_result;
        endcase
    end

    always_comb begin
        mem_o.pc      = ex_mem_q.pc;
        mem_o.inst    = ex_mem_q.inst;
        mem_o.rd_data = rd_data;
        mem_o.rd_addr = ex_mem_q.rd_addr;
        mem_o.rd_ena  = ex_mem_q.rd_ena;
    end

endmodule

// File: design/mem_wb.sv
// MEM/WB pipeline register.
// Holds on its own stall, takes a bubble behind a stalled memory stage.
`timescale 1ns/10ps

module mem_wb (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  core_pkg::mem_wb_t    mem_i,
    input  core_pkg::stall_vec_t stall_i,
    input  logic                 flush_i,
    output core_pkg::mem_wb_t    wb_o,
    output logic                 wb_hold_o
);

    import core_pkg::*;

    mem_wb_t wb_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else if (flush_i) begin
            wb_q <= '0;
        end else if (stall_i.wb_s) begin
            wb_q <= wb_q;
        end else if (stall_i.mem_s) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_i;
        end
    end

    // the content stays put for another cycle while write-back is stalled.
    assign wb_hold_o = stall_i.wb_s;

    // the write enable is masked while held, so the register file is
    // written once, on the edge the instruction actually retires.
    always_comb begin
        wb_o        = wb_q;
        wb_o.rd_ena = wb_q.rd_ena && !wb_hold_o;
    end

endmodule

// File: design/regfile.sv
// integer register file, 32 x 64 bits.
// Two read ports and an a0 tap, all bypassing the write in progress.
`timescale 1ns/10ps

module regfile (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_pkg::XLEN-1:0]       rs2_data_o,
    output logic [core_pkg::XLEN-1:0]       a0_data_o
);

    import core_pkg::*;

    localparam logic [REG_ADDR_W-1:0] A0_ADDR = 5'd10;

    logic [XLEN-1:0] regs_q [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, and a write to the same register this cycle wins.
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (we_i && (waddr_i == addr)) begin
            data = wdata_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
        a0_data_o  = read_port(A0_ADDR);
    end

endmodule

// File: design/commit_monitor.sv
// commit monitor.
// Registers each retired instruction and flags ebreak with a0 as its trap code.
`timescale 1ns/10ps

module commit_monitor (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  core_pkg::mem_wb_t         wb_i,
    input  logic                      wb_hold_i,
    input  logic [core_pkg::XLEN-1:0] a0_data_i,
    output core_pkg::commit_t         commit_o
);

    import core_pkg::*;

    logic retire;
    logic is_ebreak;

    // bubbles never retire, and a held instruction retires only when released.
    assign retire    = (wb_i.inst != '0) && !wb_hold_i;
    assign is_ebreak = (wb_i.inst == EBREAK_INST);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_o.valid <= 1'b0;
            commit_o.trap  <= 1'b0;
        end else begin
            commit_o.valid <= retire;
            commit_o.trap  <= retire && is_ebreak;
        end
    end

    // a0 already includes a write-back landing on this same edge.
    always_ff @(posedge clk) begin
        commit_o.pc        <= wb_i.pc;
        commit_o.inst      <= wb_i.inst;
        commit_o.trap_code <= a0_data_i;
    end

endmodule

// File: design/core_backend.sv
// back end of the in-order RV64 pipeline.
// Memory stage, data RAM, write-back register, register file and commit monitor.
`timescale 1ns/10ps

module core_backend #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  core_pkg::ex_mem_t               ex_i,
    input  core_pkg::stall_vec_t            stall_i,
    input  logic                            flush_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_pkg::XLEN-1:0]       rs2_data_o,
    output core_pkg::commit_t               commit_o
);

    import core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [IDX_W-1:0] ram_addr;
    logic [XLEN-1:0]  ram_wdata;
    logic [7:0]       ram_be;
    logic             ram_we;
    logic [XLEN-1:0]  ram_rdata;
    mem_wb_t          mem_rec;
    mem_wb_t          wb_rec;
    logic             wb_hold;
    logic [XLEN-1:0]  a0_data;

    data_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .be_i    (ram_be),
        .we_i    (ram_we),
        .rdata_o (ram_rdata)
    );

    mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_mem_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_be_o    (ram_be),
        .ram_we_o    (ram_we),
        .ram_rdata_i (ram_rdata),
        .mem_o       (mem_rec)
    );

    mem_wb u_mem_wb (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .mem_i     (mem_rec),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .wb_o      (wb_rec),
        .wb_hold_o (wb_hold)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .we_i       (wb_rec.rd_ena),
        .waddr_i    (wb_rec.rd_addr),
        .wdata_i    (wb_rec.rd_data),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o),
        .a0_data_o  (a0_data)
    );

    commit_monitor u_commit_monitor (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (wb_rec),
        .wb_hold_i (wb_hold),
        .a0_data_i (a0_data),
        .commit_o  (commit_o)
    );

endmodule

// File: tb/tb_core_backend.sv
// testbench for the core back end.
// Random execute records, stalls and flushes checked against a shadow pipeline model.
`timescale 1ns/10ps

module tb_core_backend;

    import core_pkg::*;

    localparam int          DMEM_WORDS     = 256;
    localparam int          RAM_BYTES      = DMEM_WORDS * 8;
    localparam int          BYTE_W         = $clog2(RAM_BYTES);
    localparam int          WINDOW_WORDS   = 16;
    localparam int          RANDOM_CYCLES  = 2000;
    localparam int          STIM_CYCLES    = WINDOW_WORDS + RANDOM_CYCLES;
    localparam int          TIMEOUT_CYCLES = STIM_CYCLES * 2 + 100;
    localparam logic [31:0] SEED           = 32'h14dd608f;

    logic                  clk;
    logic                  rst_n_i;
    ex_mem_t               ex_rec;
    stall_vec_t            stall;
    logic                  flush;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    commit_t               commit;

    // shadow pipeline, register and byte-wide memory copies.
    ex_mem_t               m_exmem;
    mem_wb_t               m_memwb;
    logic [XLEN-1:0]       m_regs [32];
    logic [7:0]            m_bytes [RAM_BYTES];
    logic                  consumed;
    logic                  pending_ebreak;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] last_rd;
    int                    prefill_idx;
    int                    cycle_count = 0;

    core_backend #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ex_i       (ex_rec),
        .stall_i    (stall),
        .flush_i    (flush),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .commit_o   (commit)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            MEM_LD, MEM_SD:          return 8;
            default:                 return 0;
        endcase
    endfunction

    function automatic logic is_load(input mem_op_e op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
    endfunction

    // memory is little endian, so byte i of a value sits at address + i.
    function automatic logic [XLEN-1:0] load_value(input mem_op_e op, input logic [XLEN-1:0] addr);
        logic [XLEN-1:0]   raw;
        logic [BYTE_W-1:0] base;
        int                n;
        n    = access_bytes(op);
        base = addr[BYTE_W-1:0];
        raw  = '0;
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = m_bytes[base + BYTE_W'(i)];
        end
        if ((op == MEM_LB || op == MEM_LH || op == MEM_LW) && raw[8*n-1]) begin
            raw = raw | (~64'd0 << (8 * n));
        end
        return raw;
    endfunction

    task automatic store_bytes(input mem_op_e op, input logic [XLEN-1:0] addr,
                               input logic [XLEN-1:0] data);
        logic [BYTE_W-1:0] base;
        base = addr[BYTE_W-1:0];
        for (int i = 0; i < access_bytes(op); i++) begin
            m_bytes[base + BYTE_W'(i)] = data[8*i +: 8];
        end
    endtask

    function automatic logic [XLEN-1:0] expected_read(input logic [REG_ADDR_W-1:0] addr,
                                                      input logic pend_we);
        if (addr == '0) begin
            return '0;
        end else if (pend_we && (m_memwb.rd_addr == addr)) begin
            return m_memwb.rd_data;
        end
        return m_regs[addr];
    endfunction

    function automatic logic [INST_W-1:0] make_inst(input logic [6:0] opcode);
        logic [31:0] r;
        r = $urandom;
        return {r[31:7], opcode};
    endfunction

    // checks the commit of this edge, then moves the shadow pipeline by one edge.
    task automatic retire_and_advance();
        logic            wr_en;
        logic            exp_valid;
        logic            exp_trap;
        logic [XLEN-1:0] a0_val;
        mem_wb_t         nxt;
        wr_en     = m_memwb.rd_ena && !stall.wb_s && (m_memwb.rd_addr != '0);
        a0_val    = (wr_en && m_memwb.rd_addr == 5'd10) ? m_memwb.rd_data : m_regs[10];
        exp_valid = (m_memwb.inst != '0) && !stall.wb_s;
        exp_trap  = exp_valid && (m_memwb.inst == EBREAK_INST);
        check_value(64'(commit.valid), 64'(exp_valid), "commit valid");
        check_value(64'(commit.trap), 64'(exp_trap), "commit trap");
        if (exp_valid) begin
            check_value(commit.pc, m_memwb.pc, "commit pc");
            check_value(64'(commit.inst), 64'(m_memwb.inst), "commit inst");
        end
        if (exp_trap) begin
            check_value(commit.trap_code, a0_val, "trap code");
        end
        nxt.pc      = m_exmem.pc;
        nxt.inst    = m_exmem.inst;
        nxt.rd_addr = m_exmem.rd_addr;
        nxt.rd_ena  = m_exmem.rd_ena;
        nxt.rd_data = is_load(m_exmem.mem_op) ? load_value(m_exmem.mem_op, m_exmem.alu_result)
                                              : m_exmem.alu_result;
        if (is_store(m_exmem.mem_op) && !stall.mem_s && !flush) begin
            store_bytes(m_exmem.mem_op, m_exmem.alu_result, m_exmem.store_data);
        end
        if (wr_en) begin
            m_regs[m_memwb.rd_addr] = m_memwb.rd_data;
            last_rd = m_memwb.rd_addr;
        end
        if (flush || (!stall.wb_s && stall.mem_s)) begin
            m_memwb = '0;
        end else if (!stall.wb_s) begin
            m_memwb = nxt;
        end
        if (flush || (!stall.mem_s && stall.ex_s)) begin
            m_exmem = '0;
        end else if (!stall.mem_s) begin
            m_exmem = ex_rec;
        end
        consumed = !flush && !stall.mem_s && !stall.ex_s;
    endtask

    task automatic gen_record();
        int          kind;
        int          n;
        int          idx;
        int          off;
        logic [3:0]  code;
        ex_mem_t     rec;
        rec = '0;
        kind = $urandom % 16;
        if (prefill_idx < WINDOW_WORDS) begin
            rec.inst       = make_inst(7'h23);
            rec.mem_op     = MEM_SD;
            rec.alu_result = 64'(prefill_idx * 8);
            rec.store_data = {$urandom, $urandom};
            prefill_idx++;
        end else if (pending_ebreak) begin
            rec.inst       = EBREAK_INST;
            pending_ebreak = 1'b0;
        end else if (kind >= 3 && kind <= 6 || kind == 15) begin
            rec.inst       = make_inst(7'h13);
            rec.rd_addr    = (kind == 15) ? 5'd10 : 5'($urandom);
            rec.rd_ena     = 1'b1;
            rec.alu_result = {$urandom, $urandom};
            pending_ebreak = (kind == 15);
        end else if (kind >= 7) begin
            code = (kind <= 10) ? 4'(8 + $urandom % 4) : 4'(1 + $urandom % 7);
            rec.mem_op     = mem_op_e'(code);
            rec.inst       = make_inst(is_store(rec.mem_op) ? 7'h23 : 7'h03);
            n              = access_bytes(rec.mem_op);
            idx            = $urandom % WINDOW_WORDS;
            off            = ($urandom % (8 / n)) * n;
            rec.alu_result = 64'(idx * 8 + off);
            rec.store_data = {$urandom, $urandom};
            rec.rd_addr    = is_store(rec.mem_op) ? 5'd0 : 5'($urandom);
            rec.rd_ena     = !is_store(rec.mem_op);
        end
        if (rec.inst != '0) begin
            rec.pc  = next_pc;
            next_pc = next_pc + 64'd4;
        end
        ex_rec = rec;
    endtask

    task automatic run_cycle(input logic calm, input logic drain);
        int         level;
        logic [4:0] mask;
        logic       pend_we;
        @(posedge clk);
        #1;
        retire_and_advance();
        if (drain) begin
            ex_rec = '0;
        end else if (consumed || flush) begin
            gen_record();
        end
        // stalls always cover a prefix of the stages, as a hazard unit drives them.
        mask = 5'd0;
        if (!calm && ($urandom % 16) >= 11) begin
            level = 1 + $urandom % 5;
            mask  = 5'((32'd1 << level) - 32'd1);
        end
        stall    = mask;
        flush    = !calm && (($urandom % 32) == 0);
        rs1_addr = ($urandom % 2 == 0) ? m_memwb.rd_addr : 5'($urandom);
        rs2_addr = last_rd;
        #1;
        pend_we = m_memwb.rd_ena && !stall.wb_s;
        check_value(rs1_data, expected_read(rs1_addr, pend_we), "rs1 read");
        check_value(rs2_data, expected_read(rs2_addr, pend_we), "rs2 read");
        check_value(64'(u_dut.ram_we),
                    64'(is_store(m_exmem.mem_op) && !stall.mem_s && !flush), "store enable");
    endtask

    // reads every register back once the pipeline has drained.
    task automatic sweep_registers();
        for (int r = 0; r < 32; r += 2) begin
            @(posedge clk);
            #1;
            rs1_addr = 5'(r);
            rs2_addr = 5'(r + 1);
            #1;
            check_value(rs1_data, m_regs[r], "final register read");
            check_value(rs2_data, m_regs[r + 1], "final register read");
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        ex_rec         = '0;
        stall          = '0;
        flush          = 1'b0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        m_exmem        = '0;
        m_memwb        = '0;
        consumed       = 1'b1;
        pending_ebreak = 1'b0;
        next_pc        = 64'h0000_0000_8000_0000;
        last_rd        = '0;
        prefill_idx    = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_value(64'(commit.valid), 64'd0, "commit valid after reset");
        check_value(64'(commit.trap), 64'd0, "commit trap after reset");
        // the first cycles fill the load window with doublewords and run unstalled.
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            run_cycle(cyc < WINDOW_WORDS + 2, 1'b0);
        end
        while (m_exmem.inst != '0 || m_memwb.inst != '0) begin
            run_cycle(1'b1, 1'b1);
        end
        run_cycle(1'b1, 1'b1);
        sweep_registers();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: core_backend.f
design/core_pkg.sv
design/data_ram.sv
design/mem_stage.sv
design/mem_wb.sv
design/regfile.sv
design/commit_monitor.sv
design/core_backend.sv
tb/tb_core_backend.sv

// File: Makefile
TOP = tb_core_backend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f core_backend.f

sim:
	verilator --binary --timing --top-module $(TOP) -f core_backend.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
